//--- design/vout_pkg.sv
package vout_pkg;

    // ----------------------------------------------------------
    // Wishbone bus
    // ----------------------------------------------------------
    localparam int WB_ADR_WIDTH = 16;
    localparam int WB_DAT_WIDTH = 32;
    localparam int WB_SEL_WIDTH = WB_DAT_WIDTH / 8;

    typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
    typedef logic [WB_DAT_WIDTH-1:0] wb_dat_t;
    typedef logic [WB_SEL_WIDTH-1:0] wb_sel_t;

    // Upper address byte selects the page, lower byte the register
    typedef logic [7:0] page_t;
    typedef logic [7:0] reg_adr_t;

    localparam page_t PAGE_ALIGN = 8'h10;
    localparam page_t PAGE_VSYNC = 8'h20;

    // ----------------------------------------------------------
    // Video types
    // ----------------------------------------------------------
    typedef logic [11:0] coord_t;
    typedef logic [23:0] pixel_in_t;
    typedef logic [35:0] pixel_out_t;

    // Timing generator page
    localparam reg_adr_t REG_VS_CTL      = 8'd0;
    localparam reg_adr_t REG_HTOTAL      = 8'd1;
    localparam reg_adr_t REG_HDISP_END   = 8'd2;
    localparam reg_adr_t REG_HSYNC_START = 8'd3;
    localparam reg_adr_t REG_HSYNC_END   = 8'd4;
    localparam reg_adr_t REG_VTOTAL      = 8'd5;
    localparam reg_adr_t REG_VDISP_END   = 8'd6;
    localparam reg_adr_t REG_VSYNC_START = 8'd7;
    localparam reg_adr_t REG_VSYNC_END   = 8'd8;
    localparam reg_adr_t REG_POL         = 8'd9;

    // Aligner page
    localparam reg_adr_t REG_AL_CTL       = 8'd0;
    localparam reg_adr_t REG_AL_UNDERFLOW = 8'd1;

    typedef enum logic {IDLE, RUN} vs_state_t;

    // Byte-lane merge of a write into the current register value
    function automatic wb_dat_t wb_apply_sel(input wb_dat_t cur, input wb_dat_t wdat,
                                             input wb_sel_t sel);
        wb_dat_t res;
        res = cur;
        for (int i = 0; i < WB_SEL_WIDTH; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = wdat[i*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

//--- design/wb_if.sv
interface wb_if;
    import vout_pkg::*;

    wb_adr_t adr;
    wb_dat_t dat_w;
    wb_dat_t dat_r;
    logic    we;
    wb_sel_t sel;
    // Page select already folded in
    logic    stb;
    logic    ack;

    modport master (
        output adr,
        output dat_w,
        output we,
        output sel,
        output stb,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  we,
        input  sel,
        input  stb,
        output dat_r,
        output ack
    );

endinterface

//--- design/wb_page_decode.sv
module wb_page_decode (
    input  vout_pkg::wb_adr_t wb_adr_i,
    input  vout_pkg::wb_dat_t wb_dat_i,
    output vout_pkg::wb_dat_t wb_dat_o,
    input  logic              wb_we_i,
    input  vout_pkg::wb_sel_t wb_sel_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    output logic              wb_ack_o,

    wb_if.master              align_bus,
    wb_if.master              vsync_bus
);
    import vout_pkg::*;

    page_t page;
    logic  cycle;
    logic  align_sel;
    logic  vsync_sel;

    assign page      = wb_adr_i[WB_ADR_WIDTH-1 -: 8];
    assign cycle     = wb_cyc_i && wb_stb_i;
    assign align_sel = cycle && (page == PAGE_ALIGN);
    assign vsync_sel = cycle && (page == PAGE_VSYNC);

    // Request side is shared, only the strobe differs
    assign align_bus.adr   = wb_adr_i;
    assign align_bus.dat_w = wb_dat_i;
    assign align_bus.we    = wb_we_i;
    assign align_bus.sel   = wb_sel_i;
    assign align_bus.stb   = align_sel;

    assign vsync_bus.adr   = wb_adr_i;
    assign vsync_bus.dat_w = wb_dat_i;
    assign vsync_bus.we    = wb_we_i;
    assign vsync_bus.sel   = wb_sel_i;
    assign vsync_bus.stb   = vsync_sel;

    // Reply merge
    always_comb begin
        if (align_sel) begin
            wb_dat_o = align_bus.dat_r;
            wb_ack_o = align_bus.ack;
        end else if (vsync_sel) begin
            wb_dat_o = vsync_bus.dat_r;
            wb_ack_o = vsync_bus.ack;
        end else begin
            // Unmapped page answers at once
            wb_dat_o = '0;
            wb_ack_o = cycle;
        end
    end

endmodule

//--- design/vsync_generator.sv
module vsync_generator #(
    parameter logic             INIT_ENABLE      = 1'b1,
    parameter vout_pkg::coord_t INIT_HTOTAL      = 12'd2200,
    parameter vout_pkg::coord_t INIT_HDISP_END   = 12'd1920,
    parameter vout_pkg::coord_t INIT_HSYNC_START = 12'd2008,
    parameter vout_pkg::coord_t INIT_HSYNC_END   = 12'd2052,
    parameter vout_pkg::coord_t INIT_VTOTAL      = 12'd1125,
    parameter vout_pkg::coord_t INIT_VDISP_END   = 12'd1080,
    parameter vout_pkg::coord_t INIT_VSYNC_START = 12'd1084,
    parameter vout_pkg::coord_t INIT_VSYNC_END   = 12'd1089,
    parameter logic             INIT_HSYNC_POL   = 1'b1,
    parameter logic             INIT_VSYNC_POL   = 1'b1
) (
    input  logic clk_i,
    input  logic rst_n_i,

    wb_if.slave  bus,

    output logic timing_vsync_o,
    output logic timing_hsync_o,
    output logic timing_de_o,
    output logic frame_start_o
);
    import vout_pkg::*;

    logic      ctl_enable;
    coord_t    htotal;
    coord_t    hdisp_end;
    coord_t    hsync_start;
    coord_t    hsync_end;
    coord_t    vtotal;
    coord_t    vdisp_end;
    coord_t    vsync_start;
    coord_t    vsync_end;
    logic [1:0] pol;

    vs_state_t state;
    coord_t    h_cnt;
    coord_t    v_cnt;
    logic      h_last;
    logic      v_last;
    logic      run;
    logic      hs_act;
    logic      vs_act;

    wb_dat_t   rd_data;
    wb_dat_t   wr_data;
    logic      wr_en;

    // ----------------------------------------------------------
    // Register access
    // ----------------------------------------------------------
    assign wr_en   = bus.stb && bus.ack && bus.we;
    assign wr_data = wb_apply_sel(rd_data, bus.dat_w, bus.sel);
    assign bus.dat_r = rd_data;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.stb && !bus.ack;
        end
    end

    always_comb begin
        case (bus.adr[7:0])
            REG_VS_CTL:      rd_data = wb_dat_t'(ctl_enable);
            REG_HTOTAL:      rd_data = wb_dat_t'(htotal);
            REG_HDISP_END:   rd_data = wb_dat_t'(hdisp_end);
            REG_HSYNC_START: rd_data = wb_dat_t'(hsync_start);
            REG_HSYNC_END:   rd_data = wb_dat_t'(hsync_end);
            REG_VTOTAL:      rd_data = wb_dat_t'(vtotal);
            REG_VDISP_END:   rd_data = wb_dat_t'(vdisp_end);
            REG_VSYNC_START: rd_data = wb_dat_t'(vsync_start);
            REG_VSYNC_END:   rd_data = wb_dat_t'(vsync_end);
            REG_POL:         rd_data = wb_dat_t'(pol);
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctl_enable  <= INIT_ENABLE;
            htotal      <= INIT_HTOTAL;
            hdisp_end   <= INIT_HDISP_END;
            hsync_start <= INIT_HSYNC_START;
            hsync_end   <= INIT_HSYNC_END;
            vtotal      <= INIT_VTOTAL;
            vdisp_end   <= INIT_VDISP_END;
            vsync_start <= INIT_VSYNC_START;
            vsync_end   <= INIT_VSYNC_END;
            pol         <= {INIT_VSYNC_POL, INIT_HSYNC_POL};
        end else if (wr_en) begin
            case (bus.adr[7:0])
                REG_VS_CTL:      ctl_enable  <= wr_data[0];
                REG_HTOTAL:      htotal      <= wr_data[11:0];
                REG_HDISP_END:   hdisp_end   <= wr_data[11:0];
                REG_HSYNC_START: hsync_start <= wr_data[11:0];
                REG_HSYNC_END:   hsync_end   <= wr_data[11:0];
                REG_VTOTAL:      vtotal      <= wr_data[11:0];
                REG_VDISP_END:   vdisp_end   <= wr_data[11:0];
                REG_VSYNC_START: vsync_start <= wr_data[11:0];
                REG_VSYNC_END:   vsync_end   <= wr_data[11:0];
                REG_POL:         pol         <= wr_data[1:0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Counters
    // ----------------------------------------------------------
    // >= keeps the counter bounded if totals shrink mid-frame
    assign h_last = (h_cnt >= htotal - 12'd1);
    assign v_last = (v_cnt >= vtotal - 12'd1);
    assign run    = (state == RUN);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!run || !ctl_enable) begin
            state <= ctl_enable ? RUN : IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 12'd1;
        end else begin
            h_cnt <= h_cnt + 12'd1;
        end
    end

    // Registered outputs, one cycle behind the counters
    assign hs_act = run && (h_cnt >= hsync_start) && (h_cnt < hsync_end);
    assign vs_act = run && (v_cnt >= vsync_start) && (v_cnt < vsync_end);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            timing_hsync_o <= !INIT_HSYNC_POL;
            timing_vsync_o <= !INIT_VSYNC_POL;
            timing_de_o    <= 1'b0;
            frame_start_o  <= 1'b0;
        end else begin
            timing_hsync_o <= !(hs_act ^ pol[0]);
            timing_vsync_o <= !(vs_act ^ pol[1]);
            timing_de_o    <= run && (h_cnt < hdisp_end) && (v_cnt < vdisp_end);
            frame_start_o  <= run && (h_cnt == '0) && (v_cnt == '0)
                              && (hdisp_end != '0) && (vdisp_end != '0);
        end
    end

endmodule

//--- design/vout_stream_align.sv
module vout_stream_align #(
    parameter logic INIT_HSYNC_POL = 1'b1,
    parameter logic INIT_VSYNC_POL = 1'b1
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    wb_if.slave                  bus,

    input  logic                 timing_vsync_i,
    input  logic                 timing_hsync_i,
    input  logic                 timing_de_i,
    input  logic                 frame_start_i,

    input  vout_pkg::pixel_in_t  s_data_i,
    input  logic                 s_user_i,
    input  logic                 s_valid_i,
    output logic                 s_ready_o,

    output logic                 vsync_o,
    output logic                 hsync_o,
    output logic                 de_o,
    output vout_pkg::pixel_out_t pixel_o
);
    import vout_pkg::*;

    logic    enable;
    logic    locked;
    logic    fire;
    logic    take;
    logic    underflow;
    logic    wr_en;
    wb_dat_t uf_count;
    wb_dat_t rd_data;
    wb_dat_t wr_data;

    // 8 to 12 bits per channel, upper nibble repeated below
    function automatic pixel_out_t expand(input pixel_in_t p);
        pixel_out_t res;
        for (int c = 0; c < 3; c++) begin
            res[c*12 +: 12] = {p[c*8 +: 8], p[c*8+4 +: 4]};
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // Stream side
    // ----------------------------------------------------------
    always_comb begin
        if (!enable) begin
            s_ready_o = 1'b0;
        end else if (frame_start_i) begin
            s_ready_o = 1'b1;
        end else if (locked) begin
            // Mid-frame user beat waits for the next frame start
            s_ready_o = timing_de_i && !s_user_i;
        end else begin
            s_ready_o = !s_user_i;
        end
    end

    assign fire      = s_valid_i && s_ready_o;
    assign take      = fire && (frame_start_i ? s_user_i : locked);
    assign underflow = enable && locked && timing_de_i && !take;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            locked <= 1'b0;
        end else if (!enable) begin
            locked <= 1'b0;
        end else if (frame_start_i && s_valid_i) begin
            locked <= s_user_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vsync_o <= !INIT_VSYNC_POL;
            hsync_o <= !INIT_HSYNC_POL;
            de_o    <= 1'b0;
            pixel_o <= '0;
        end else begin
            vsync_o <= timing_vsync_i;
            hsync_o <= timing_hsync_i;
            de_o    <= timing_de_i;
            pixel_o <= take ? expand(s_data_i) : '0;
        end
    end

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    assign wr_en     = bus.stb && bus.ack && bus.we;
    assign wr_data   = wb_apply_sel(rd_data, bus.dat_w, bus.sel);
    assign bus.dat_r = rd_data;

    always_comb begin
        case (bus.adr[7:0])
            REG_AL_CTL:       rd_data = wb_dat_t'(enable);
            REG_AL_UNDERFLOW: rd_data = uf_count;
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack  <= 1'b0;
            enable   <= 1'b0;
            uf_count <= '0;
        end else begin
            bus.ack <= bus.stb && !bus.ack;
            if (wr_en && (bus.adr[7:0] == REG_AL_CTL)) begin
                enable <= wr_data[0];
            end
            // Clear wins over a same-cycle underflow
            if (wr_en && (bus.adr[7:0] == REG_AL_UNDERFLOW)) begin
                uf_count <= '0;
            end else if (underflow && (uf_count != '1)) begin
                uf_count <= uf_count + 1'b1;
            end
        end
    end

endmodule

//--- design/vout_top.sv
module vout_top #(
    parameter logic             INIT_ENABLE      = 1'b1,
    parameter vout_pkg::coord_t INIT_HTOTAL      = 12'd2200,
    parameter vout_pkg::coord_t INIT_HDISP_END   = 12'd1920,
    parameter vout_pkg::coord_t INIT_HSYNC_START = 12'd2008,
    parameter vout_pkg::coord_t INIT_HSYNC_END   = 12'd2052,
    parameter vout_pkg::coord_t INIT_VTOTAL      = 12'd1125,
    parameter vout_pkg::coord_t INIT_VDISP_END   = 12'd1080,
    parameter vout_pkg::coord_t INIT_VSYNC_START = 12'd1084,
    parameter vout_pkg::coord_t INIT_VSYNC_END   = 12'd1089,
    parameter logic             INIT_HSYNC_POL   = 1'b1,
    parameter logic             INIT_VSYNC_POL   = 1'b1
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  vout_pkg::wb_adr_t    wb_adr_i,
    input  vout_pkg::wb_dat_t    wb_dat_i,
    output vout_pkg::wb_dat_t    wb_dat_o,
    input  logic                 wb_we_i,
    input  vout_pkg::wb_sel_t    wb_sel_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    output logic                 wb_ack_o,

    input  vout_pkg::pixel_in_t  s_data_i,
    input  logic                 s_user_i,
    input  logic                 s_valid_i,
    output logic                 s_ready_o,

    output logic                 vsync_o,
    output logic                 hsync_o,
    output logic                 de_o,
    output vout_pkg::pixel_out_t pixel_o
);

    logic timing_vsync;
    logic timing_hsync;
    logic timing_de;
    logic frame_start;

    wb_if align_bus ();
    wb_if vsync_bus ();

    // ----------------------------------------------------------
    // Register pages
    // ----------------------------------------------------------
    wb_page_decode u_decode (
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_we_i   (wb_we_i),
        .wb_sel_i  (wb_sel_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_ack_o  (wb_ack_o),
        .align_bus (align_bus.master),
        .vsync_bus (vsync_bus.master)
    );

    vsync_generator #(
        .INIT_ENABLE      (INIT_ENABLE),
        .INIT_HTOTAL      (INIT_HTOTAL),
        .INIT_HDISP_END   (INIT_HDISP_END),
        .INIT_HSYNC_START (INIT_HSYNC_START),
        .INIT_HSYNC_END   (INIT_HSYNC_END),
        .INIT_VTOTAL      (INIT_VTOTAL),
        .INIT_VDISP_END   (INIT_VDISP_END),
        .INIT_VSYNC_START (INIT_VSYNC_START),
        .INIT_VSYNC_END   (INIT_VSYNC_END),
        .INIT_HSYNC_POL   (INIT_HSYNC_POL),
        .INIT_VSYNC_POL   (INIT_VSYNC_POL)
    ) u_vsync (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .bus            (vsync_bus.slave),
        .timing_vsync_o (timing_vsync),
        .timing_hsync_o (timing_hsync),
        .timing_de_o    (timing_de),
        .frame_start_o  (frame_start)
    );

    // Stream lock and pixel output
    vout_stream_align #(
        .INIT_HSYNC_POL (INIT_HSYNC_POL),
        .INIT_VSYNC_POL (INIT_VSYNC_POL)
    ) u_align (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .bus            (align_bus.slave),
        .timing_vsync_i (timing_vsync),
        .timing_hsync_i (timing_hsync),
        .timing_de_i    (timing_de),
        .frame_start_i  (frame_start),
        .s_data_i       (s_data_i),
        .s_user_i       (s_user_i),
        .s_valid_i      (s_valid_i),
        .s_ready_o      (s_ready_o),
        .vsync_o        (vsync_o),
        .hsync_o        (hsync_o),
        .de_o           (de_o),
        .pixel_o        (pixel_o)
    );

endmodule

//--- dv/tb_vout_top.sv
module tb_vout_top;
    import vout_pkg::*;

    localparam int FRAME_CYCLES   = 24 * 10;
    localparam int FRAME_PIXELS   = 16 * 6;
    // Vsync covers lines 7 up to 8, one line of 24 cycles
    localparam int VSYNC_CYCLES   = 24 * (8 - 7);
    // Ten frames of video and 400 cycles of register traffic
    localparam int TIMEOUT_CYCLES = 10 * FRAME_CYCLES + 400;

    logic       clk_i;
    logic       rst_n_i;
    wb_adr_t    wb_adr_i;
    wb_dat_t    wb_dat_i;
    wb_dat_t    wb_dat_o;
    logic       wb_we_i;
    wb_sel_t    wb_sel_i;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_ack_o;
    pixel_in_t  s_data_i;
    logic       s_user_i;
    logic       s_valid_i;
    logic       s_ready_o;
    logic       vsync_o;
    logic       hsync_o;
    logic       de_o;
    pixel_out_t pixel_o;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;
    int          pixels_checked = 0;
    logic [31:0] lfsr = 32'h7913;

    // Stream source and reference model
    pixel_in_t  beat_data = '0;
    logic       beat_user = 1'b0;
    logic       src_on = 1'b0;
    logic       locked_m = 1'b0;
    logic       xfer_pend = 1'b0;
    logic       skip_pend = 1'b0;
    int         junk_left = 0;
    int         withhold_left = 0;
    int         beat_idx = 0;
    pixel_out_t exp_q[$];

    vout_top #(
        .INIT_HTOTAL      (12'd24),
        .INIT_HDISP_END   (12'd16),
        .INIT_HSYNC_START (12'd18),
        .INIT_HSYNC_END   (12'd20),
        .INIT_VTOTAL      (12'd10),
        .INIT_VDISP_END   (12'd6),
        .INIT_VSYNC_START (12'd7),
        .INIT_VSYNC_END   (12'd8)
    ) dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Random numbers and checks
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    // Upper nibble of each 8-bit channel repeated below it
    function automatic pixel_out_t widen_pixel(input pixel_in_t p);
        logic [7:0] b;
        logic [7:0] g;
        logic [7:0] r;
        b = p[7:0];
        g = p[15:8];
        r = p[23:16];
        return {r, r[7:4], g, g[7:4], b, b[7:4]};
    endfunction

    task automatic check_equal(input string name, input logic [63:0] act,
                               input logic [63:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, act, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    // ----------------------------------------------------------
    // Wishbone master
    // ----------------------------------------------------------
    task automatic wb_access(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                             output wb_dat_t rdat, output logic acked);
        acked = 1'b0;
        rdat  = '0;
        @(posedge clk_i);
        #10;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_we_i  = we;
        wb_sel_i = 4'hf;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        for (int i = 0; i < 16 && !acked; i++) begin
            @(negedge clk_i);
            if (wb_ack_o) begin
                acked = 1'b1;
                rdat  = wb_dat_o;
            end
        end
        if (!acked) begin
            $display("Bus access to 0x%0h was never acknowledged", adr);
            errors++;
        end
        @(posedge clk_i);
        #10;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
        wb_dat_t rdat;
        logic    acked;
        wb_access(adr, 1'b1, wdat, rdat, acked);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
        logic acked;
        wb_access(adr, 1'b0, '0, rdat, acked);
    endtask

    // ----------------------------------------------------------
    // Stream source and output checker
    // ----------------------------------------------------------
    task automatic next_beat();
        beat_data = pixel_in_t'(rand_bits(24));
        if (junk_left > 0) begin
            junk_left--;
            beat_user = 1'b0;
        end else begin
            beat_user = (beat_idx == 0);
            beat_idx  = (beat_idx + 1) % FRAME_PIXELS;
        end
    endtask

    always @(posedge clk_i) begin
        #10;
        if (xfer_pend || skip_pend) begin
            if (skip_pend && withhold_left > 0) begin
                withhold_left--;
            end
            next_beat();
            xfer_pend = 1'b0;
            skip_pend = 1'b0;
        end
        s_data_i  = beat_data;
        s_user_i  = beat_user;
        s_valid_i = src_on && !(withhold_left > 0 && locked_m && !beat_user);
    end

    always @(negedge clk_i) begin
        if (locked_m && de_o) begin
            if (exp_q.size() == 0) begin
                $display("Pixel shown on the output with no pixel expected");
                errors++;
            end else begin
                check_equal("pixel_o", 64'(pixel_o), 64'(exp_q.pop_front()));
                pixels_checked++;
            end
        end else if (!locked_m && pixel_o != '0) begin
            $display("Pixel 0x%0h shown on the output before lock", pixel_o);
            errors++;
        end
        if (s_valid_i && s_ready_o) begin
            xfer_pend = 1'b1;
            if (beat_user) begin
                locked_m = 1'b1;
            end
            if (locked_m) begin
                exp_q.push_back(widen_pixel(beat_data));
            end
        end else if (locked_m && s_ready_o && !s_valid_i) begin
            skip_pend = 1'b1;
            exp_q.push_back('0);
        end
    end

    task automatic wait_pixels(input int n);
        int target;
        target = pixels_checked + n;
        while (pixels_checked < target) begin
            @(posedge clk_i);
        end
    endtask

    // Counts over one frame, starting at the rising edge of vsync
    task automatic measure_frame(input logic act, output int de_cnt, output int de_lines,
                                 output int hs_cnt, output int vs_cnt,
                                 output int bad_runs);
        logic prev_vs;
        int   de_run;
        int   hs_run;
        de_cnt   = 0;
        de_lines = 0;
        hs_cnt   = 0;
        vs_cnt   = 0;
        bad_runs = 0;
        de_run   = 0;
        hs_run   = 0;
        @(negedge clk_i);
        prev_vs = (vsync_o == act);
        while (!(vsync_o == act && !prev_vs)) begin
            prev_vs = (vsync_o == act);
            @(negedge clk_i);
        end
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (de_o) begin
                de_cnt++;
                de_run++;
            end else if (de_run > 0) begin
                de_lines++;
                bad_runs += (de_run != 16) ? 1 : 0;
                de_run = 0;
            end
            if (hsync_o == act) begin
                hs_cnt++;
                hs_run++;
            end else if (hs_run > 0) begin
                bad_runs += (hs_run != 2) ? 1 : 0;
                hs_run = 0;
            end
            vs_cnt += (vsync_o == act) ? 1 : 0;
            @(negedge clk_i);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        int      start;
        int      init_vals[10];
        int      de_cnt;
        int      de_lines;
        int      hs_cnt;
        int      vs_cnt;
        int      bad_runs;
        wb_dat_t val;
        wb_dat_t rdat;
        logic    acked;

        init_vals = '{1, 24, 16, 18, 20, 10, 6, 7, 8, 3};
        rst_n_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        wb_we_i   = 1'b0;
        wb_sel_i  = '0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        s_data_i  = '0;
        s_user_i  = 1'b0;
        s_valid_i = 1'b0;
        repeat (16) @(posedge clk_i);
        #10;
        rst_n_i = 1'b1;

        start = errors;
        for (int r = 0; r < 10; r++) begin
            if (r == 0) begin
                val = rand_bits(1);
            end else if (r == 9) begin
                val = rand_bits(2);
            end else begin
                val = rand_bits(12);
            end
            wb_write(16'h2000 | wb_adr_t'(r), val);
            wb_read(16'h2000 | wb_adr_t'(r), rdat);
            check_equal($sformatf("vsync reg %0d", r), 64'(rdat), 64'(val));
            wb_write(16'h2000 | wb_adr_t'(r), wb_dat_t'(init_vals[r]));
        end
        wb_access(16'h3004, 1'b0, '0, rdat, acked);
        check_equal("wb_ack_o", 64'(acked), 64'd1);
        check_equal("wb_dat_o", 64'(rdat), 64'd0);
        end_test("register_readback", start);

        start = errors;
        measure_frame(1'b1, de_cnt, de_lines, hs_cnt, vs_cnt, bad_runs);
        check_equal("de cycles", 64'(de_cnt), 64'(FRAME_PIXELS));
        check_equal("de lines", 64'(de_lines), 64'd6);
        check_equal("hsync cycles", 64'(hs_cnt), 64'd20);
        check_equal("vsync cycles", 64'(vs_cnt), 64'(VSYNC_CYCLES));
        check_equal("bad pulse widths", 64'(bad_runs), 64'd0);
        end_test("frame_geometry", start);

        // Junk beats wait at the input before the aligner is enabled
        start     = errors;
        junk_left = 20;
        next_beat();
        src_on = 1'b1;
        repeat (5) @(posedge clk_i);
        // Disabled aligner leaves the junk waiting
        check_equal("s_ready_o", 64'(s_ready_o), 64'd0);
        check_equal("junk beats left", 64'(junk_left), 64'd19);
        wb_write(16'h1000, 32'd1);
        while (!locked_m) begin
            @(posedge clk_i);
        end
        end_test("lock_recovery", start);

        start = errors;
        wait_pixels(2 * FRAME_PIXELS);
        end_test("pixel_order", start);

        start = errors;
        wb_write(16'h1001, 32'd0);
        withhold_left = 5;
        while (withhold_left > 0) begin
            @(posedge clk_i);
        end
        wait_pixels(FRAME_PIXELS);
        wb_read(16'h1001, rdat);
        check_equal("underflow count", 64'(rdat), 64'd5);
        wb_write(16'h1001, 32'd0);
        wb_read(16'h1001, rdat);
        check_equal("underflow after clear", 64'(rdat), 64'd0);
        end_test("underflow", start);

        start = errors;
        wb_write(16'h2009, 32'd0);
        measure_frame(1'b0, de_cnt, de_lines, hs_cnt, vs_cnt, bad_runs);
        check_equal("hsync low cycles", 64'(hs_cnt), 64'd20);
        check_equal("vsync low cycles", 64'(vs_cnt), 64'(VSYNC_CYCLES));
        check_equal("bad pulse widths", 64'(bad_runs), 64'd0);
        end_test("polarity", start);

        $display("tests run %0d, tests failed %0d, errors %0d, pixels checked %0d",
                 tests_run, tests_failed, errors, pixels_checked);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
design/vout_pkg.sv
design/wb_if.sv
design/wb_page_decode.sv
design/vsync_generator.sv
design/vout_stream_align.sv
design/vout_top.sv
dv/tb_vout_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       := tb_vout_top
FILELIST  := sim.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
